// File: nes_video_pkg.sv
package nes_video_pkg;

  typedef logic [5:0] pal_idx_t;   // NES system palette index
  typedef logic [9:0] coord_t;

  // 8 bit colour, r in the top bits
  typedef struct packed {
    logic [2:0] r;
    logic [2:0] g;
    logic [1:0] b;
  } rgb332_t;

  // visible frame and blanking, in clocks and lines
  localparam int FRAME_WIDTH  = 24;
  localparam int FRAME_HEIGHT = 12;
  localparam int HBLANK       = 4;
  localparam int VBLANK       = 2;
  localparam int LINE_TOTAL   = FRAME_WIDTH + HBLANK;
  localparam int FRAME_TOTAL  = FRAME_HEIGHT + VBLANK;

  // nes image window inside the frame
  localparam int IMAGE_WIDTH  = 16;
  localparam int IMAGE_HEIGHT = 8;
  localparam int X_OFFSET     = 4;
  localparam int Y_OFFSET     = 2;

  localparam int VBLANK_WAIT  = 20;   // idle clocks between frames
  localparam int WAIT_CNT_W   = $clog2(VBLANK_WAIT);
  typedef logic [WAIT_CNT_W-1:0] wait_cnt_t;

  localparam rgb332_t BG_COLOR = 8'h25;

  // fifo depth is also the sender's starting credit
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  typedef logic [FIFO_AW-1:0] fifo_ptr_t;
  typedef logic [FIFO_AW:0]   fifo_cnt_t;   // one extra bit to hold FIFO_DEPTH

endpackage

// File: raster_if.sv
`timescale 1ns/1ps

interface raster_if ();

  logic                  req;      // pop request, one per image pixel
  logic                  active;   // position inside the image window
  nes_video_pkg::coord_t x;        // image coordinates, zero outside window
  nes_video_pkg::coord_t y;
  logic                  hsync;    // high over the visible part of a line
  logic                  sof;      // frame origin

  modport src (
    output req, active, x, y, hsync, sof
  );

  modport dst (
    input req, active, x, y, hsync, sof
  );

endinterface

// File: pix_fifo.sv
`timescale 1ns/1ps

module pix_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_push,
  input  nes_video_pkg::pal_idx_t i_idx,
  input  logic                    i_pop,
  output logic                    o_valid,
  output nes_video_pkg::pal_idx_t o_idx,
  output logic                    o_credit
);

  nes_video_pkg::pal_idx_t  mem [nes_video_pkg::FIFO_DEPTH];
  nes_video_pkg::fifo_ptr_t wr_ptr;
  nes_video_pkg::fifo_ptr_t rd_ptr;
  nes_video_pkg::fifo_cnt_t count;
  logic                     full;
  logic                     do_push;
  logic                     do_pop;

  function automatic nes_video_pkg::fifo_ptr_t ptr_next(input nes_video_pkg::fifo_ptr_t p);
    return (p == nes_video_pkg::fifo_ptr_t'(nes_video_pkg::FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == nes_video_pkg::fifo_cnt_t'(nes_video_pkg::FIFO_DEPTH));
  assign o_valid  = (count != '0);
  assign o_idx    = mem[rd_ptr];          // head is visible without a pop
  assign do_push  = i_push && !full;      // sender's credits keep this from dropping
  assign do_pop   = i_pop && o_valid;
  assign o_credit = do_pop;               // one credit back per real pop

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= i_idx;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // both or neither
      endcase
    end
  end

endmodule

// File: raster_timer.sv
`timescale 1ns/1ps

module raster_timer (
  input  logic   clk,
  input  logic   rst,
  output logic   o_vblank,
  raster_if.src  rif
);

  typedef enum logic {
    ST_WAIT,
    ST_VIDEO
  } state_t;

  state_t                   state;
  nes_video_pkg::coord_t    x_pos;
  nes_video_pkg::coord_t    y_pos;
  nes_video_pkg::wait_cnt_t wait_cnt;
  logic                     in_video;
  logic                     in_image;
  logic                     line_end;
  logic                     frame_end;

  assign in_video  = (state == ST_VIDEO);
  assign line_end  = (x_pos == nes_video_pkg::coord_t'(nes_video_pkg::LINE_TOTAL - 1));
  assign frame_end = line_end &&
                     (y_pos == nes_video_pkg::coord_t'(nes_video_pkg::FRAME_TOTAL - 1));

  // image window, placed by the offsets inside the visible frame
  assign in_image = in_video &&
    (x_pos >= nes_video_pkg::coord_t'(nes_video_pkg::X_OFFSET)) &&
    (x_pos <  nes_video_pkg::coord_t'(nes_video_pkg::X_OFFSET + nes_video_pkg::IMAGE_WIDTH)) &&
    (y_pos >= nes_video_pkg::coord_t'(nes_video_pkg::Y_OFFSET)) &&
    (y_pos <  nes_video_pkg::coord_t'(nes_video_pkg::Y_OFFSET + nes_video_pkg::IMAGE_HEIGHT));

  assign rif.active = in_image;
  assign rif.req    = in_image;   // one fifo pop per image pixel
  assign rif.x      = in_image ? x_pos - nes_video_pkg::coord_t'(nes_video_pkg::X_OFFSET) : '0;
  assign rif.y      = in_image ? y_pos - nes_video_pkg::coord_t'(nes_video_pkg::Y_OFFSET) : '0;
  assign rif.hsync  = in_video &&
                      (x_pos < nes_video_pkg::coord_t'(nes_video_pkg::FRAME_WIDTH)) &&
                      (y_pos < nes_video_pkg::coord_t'(nes_video_pkg::FRAME_HEIGHT));
  assign rif.sof    = in_video && (x_pos == '0) && (y_pos == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_WAIT;
      wait_cnt <= '0;
      x_pos    <= '0;
      y_pos    <= '0;
      o_vblank <= 1'b1;
    end else begin
      o_vblank <= (state == ST_WAIT);   // lines up with the colour stage register
      case (state)
        ST_WAIT: begin
          if (wait_cnt == nes_video_pkg::wait_cnt_t'(nes_video_pkg::VBLANK_WAIT - 1)) begin
            wait_cnt <= '0;
            x_pos    <= '0;
            y_pos    <= '0;
            state    <= ST_VIDEO;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        ST_VIDEO: begin
          if (line_end) begin
            x_pos <= '0;
            if (frame_end) begin
              y_pos <= '0;
              state <= ST_WAIT;   // last blank line done
            end else begin
              y_pos <= y_pos + 1'b1;
            end
          end else begin
            x_pos <= x_pos + 1'b1;
          end
        end
        default: state <= ST_WAIT;
      endcase
    end
  end

endmodule

// File: palette_lut.sv
`timescale 1ns/1ps

module palette_lut (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    i_fifo_valid,
  input  nes_video_pkg::pal_idx_t i_idx,
  raster_if.dst                   rif,
  output nes_video_pkg::rgb332_t  o_rgb,
  output logic                    o_de,
  output logic                    o_underrun,
  output logic                    o_hsync,
  output logic                    o_sof
);

  nes_video_pkg::rgb332_t lut_rgb;
  logic                   show_pix;

  assign show_pix = rif.active && i_fifo_valid;

  // approximation of the nes system palette
  always_comb begin
    case (i_idx)
      6'h00: lut_rgb = {3'h3, 3'h3, 2'h1};
      6'h01: lut_rgb = {3'h1, 3'h0, 2'h2};
      6'h02: lut_rgb = {3'h0, 3'h0, 2'h2};
      6'h03: lut_rgb = {3'h2, 3'h0, 2'h2};
      6'h04: lut_rgb = {3'h4, 3'h0, 2'h1};
      6'h05, 6'h06: lut_rgb = {3'h5, 3'h0, 2'h0};
      6'h07: lut_rgb = {3'h3, 3'h0, 2'h0};
      6'h08: lut_rgb = {3'h2, 3'h1, 2'h0};
      6'h09, 6'h0a: lut_rgb = {3'h0, 3'h2, 2'h0};
      6'h0b: lut_rgb = {3'h0, 3'h1, 2'h0};
      6'h0c: lut_rgb = {3'h0, 3'h1, 2'h1};
      6'h10: lut_rgb = {3'h5, 3'h5, 2'h2};
      6'h11: lut_rgb = {3'h0, 3'h3, 2'h3};
      6'h12: lut_rgb = {3'h1, 3'h1, 2'h3};
      6'h13: lut_rgb = {3'h4, 3'h0, 2'h3};
      6'h14: lut_rgb = {3'h5, 3'h0, 2'h2};
      6'h15: lut_rgb = {3'h7, 3'h0, 2'h1};
      6'h16: lut_rgb = {3'h6, 3'h1, 2'h0};
      6'h17: lut_rgb = {3'h6, 3'h2, 2'h0};
      6'h18: lut_rgb = {3'h4, 3'h3, 2'h0};
      6'h19, 6'h1b: lut_rgb = {3'h0, 3'h4, 2'h0};
      6'h1a: lut_rgb = {3'h0, 3'h5, 2'h0};
      6'h1c: lut_rgb = {3'h0, 3'h4, 2'h2};
      6'h20, 6'h30: lut_rgb = {3'h7, 3'h7, 2'h3};   // white
      6'h21: lut_rgb = {3'h1, 3'h5, 2'h3};
      6'h22: lut_rgb = {3'h2, 3'h4, 2'h3};
      6'h23: lut_rgb = {3'h5, 3'h4, 2'h3};
      6'h24: lut_rgb = {3'h7, 3'h3, 2'h3};
      6'h25: lut_rgb = {3'h7, 3'h3, 2'h2};
      6'h26: lut_rgb = {3'h7, 3'h3, 2'h1};
      6'h27: lut_rgb = {3'h7, 3'h4, 2'h0};
      6'h28: lut_rgb = {3'h7, 3'h5, 2'h0};
      6'h29: lut_rgb = {3'h4, 3'h6, 2'h0};
      6'h2a: lut_rgb = {3'h2, 3'h6, 2'h1};
      6'h2b: lut_rgb = {3'h2, 3'h7, 2'h2};
      6'h2c: lut_rgb = {3'h0, 3'h7, 2'h3};
      6'h31, 6'h3b: lut_rgb = {3'h5, 3'h7, 2'h3};
      6'h32, 6'h33: lut_rgb = {3'h6, 3'h6, 2'h3};
      6'h34, 6'h35: lut_rgb = {3'h7, 3'h6, 2'h3};
      6'h36: lut_rgb = {3'h7, 3'h5, 2'h2};
      6'h37: lut_rgb = {3'h7, 3'h6, 2'h2};
      6'h38, 6'h39: lut_rgb = {3'h7, 3'h7, 2'h2};
      6'h3a: lut_rgb = {3'h5, 3'h7, 2'h2};
      6'h3c: lut_rgb = {3'h4, 3'h7, 2'h3};
      default: lut_rgb = {3'h0, 3'h0, 2'h0};   // columns d to f are black
    endcase
  end

  // single output register stage
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rgb      <= nes_video_pkg::BG_COLOR;
      o_de       <= 1'b0;
      o_underrun <= 1'b0;
      o_hsync    <= 1'b0;
      o_sof      <= 1'b0;
    end else begin
      o_rgb      <= show_pix ? lut_rgb : nes_video_pkg::BG_COLOR;
      o_de       <= rif.active;
      o_underrun <= rif.active && !i_fifo_valid;   // starved image pixel
      o_hsync    <= rif.hsync;
      o_sof      <= rif.sof;
    end
  end

endmodule

// File: nes_video_top.sv
`timescale 1ns/1ps

module nes_video_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       i_pix_valid,   // sender holds a credit
  input  logic [5:0] i_pix_idx,
  output logic       o_credit,
  output logic       o_vblank,
  output logic       o_hsync,
  output logic       o_sof,
  output logic       o_de,
  output logic       o_underrun,
  output logic [2:0] o_r,
  output logic [2:0] o_g,
  output logic [1:0] o_b
);

  logic                    fifo_valid;
  nes_video_pkg::pal_idx_t fifo_idx;
  nes_video_pkg::rgb332_t  rgb;

  raster_if rif ();

  pix_fifo u_fifo (
    .clk      (clk),
    .rst      (rst),
    .i_push   (i_pix_valid),
    .i_idx    (i_pix_idx),
    .i_pop    (rif.req),
    .o_valid  (fifo_valid),
    .o_idx    (fifo_idx),
    .o_credit (o_credit)
  );

  raster_timer u_timer (
    .clk      (clk),
    .rst      (rst),
    .o_vblank (o_vblank),
    .rif      (rif)
  );

  palette_lut u_lut (
    .clk          (clk),
    .rst          (rst),
    .i_fifo_valid (fifo_valid),
    .i_idx        (fifo_idx),
    .rif          (rif),
    .o_rgb        (rgb),
    .o_de         (o_de),
    .o_underrun   (o_underrun),
    .o_hsync      (o_hsync),
    .o_sof        (o_sof)
  );

  assign o_r = rgb.r;
  assign o_g = rgb.g;
  assign o_b = rgb.b;

endmodule

// File: nes_video_props.sv
`timescale 1ns/1ps

module nes_video_props (
  input logic clk,
  input logic rst,
  input logic i_push,
  input logic fifo_full,
  input logic o_credit,
  input logic o_de,
  input logic o_underrun,
  input logic o_vblank,
  input logic o_sof
);

  // credits keep the sender off a full fifo
  a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(i_push && fifo_full))
    else $error("push while fifo full");
  // a returned credit means a fifo pixel on the next output cycle
  a_credit_shown: assert property (@(posedge clk) disable iff (rst)
                                   o_credit |=> (o_de && !o_underrun))
    else $error("credit without a shown pixel");
  a_sof_pulse: assert property (@(posedge clk) disable iff (rst) o_sof |=> !o_sof)
    else $error("sof longer than one cycle");
  a_vblank_de: assert property (@(posedge clk) disable iff (rst) !(o_vblank && o_de))
    else $error("data enable during vblank");

endmodule

bind nes_video_top nes_video_props u_props (
  .clk        (clk),
  .rst        (rst),
  .i_push     (i_pix_valid),
  .fifo_full  (u_fifo.full),
  .o_credit   (o_credit),
  .o_de       (o_de),
  .o_underrun (o_underrun),
  .o_vblank   (o_vblank),
  .o_sof      (o_sof)
);

// File: tb_nes_video_ref.svh
`ifndef TB_NES_VIDEO_REF_SVH
`define TB_NES_VIDEO_REF_SVH

// nes palette as rgb332 bytes, one row per palette column group, entry 0 leftmost
function automatic nes_video_pkg::rgb332_t ref_rgb(input nes_video_pkg::pal_idx_t idx);
  logic [127:0] row;
  case (idx[5:4])
    2'd0:    row = 128'h6d220242_81a0a060_44080804_05000000;
    2'd1:    row = 128'hb60f2783_a2e1c4c8_8c101410_12000000;
    2'd2:    row = 128'hff3753b3_efeeedf0_f498595e_1f000000;
    default: row = 128'hffbfdbdb_fbfbf6fa_fefebebf_9f000000;
  endcase
  return nes_video_pkg::rgb332_t'(row[(15 - idx[3:0]) * 8 +: 8]);
endfunction

// fibonacci lfsr, taps 32 22 2 1, new bit lands in bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

task automatic check_rgb(input string name, input nes_video_pkg::rgb332_t got,
                         input nes_video_pkg::rgb332_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
  end
endtask

// per-frame and end of run totals
task automatic check_count(input string name, input int got, input int exp);
  if (got != exp) begin
    err_cnt++;
    $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
  end
endtask

`endif

// File: tb_nes_video.sv
`timescale 1ns/1ps

module tb_nes_video;

  localparam int NUM_FRAMES  = 4;
  localparam int PAUSE_FRAME = 1;      // sender goes quiet for this frame
  localparam int MAX_CYCLES  = 3000;

  logic       clk;
  logic       rst;
  logic       i_pix_valid;
  logic [5:0] i_pix_idx;
  logic       o_credit, o_vblank, o_hsync, o_sof, o_de, o_underrun;
  logic [2:0] o_r, o_g;
  logic [1:0] o_b;

  int          err_cnt = 0;
  int          credits = nes_video_pkg::FIFO_DEPTH;
  int          frames_done = 0;
  int          credit_pulses = 0, shown_cnt = 0, pause_underruns = 0;
  int          de_cnt = 0, sof_cnt = 0, hsync_runs = 0;
  logic        rst_d1 = 1'b0, rst_d2 = 1'b0, armed = 1'b0;
  logic        hsync_q = 1'b0, vblank_q = 1'b1;
  logic [31:0] lfsr = 32'hb8911644;
  nes_video_pkg::pal_idx_t exp_q[$];

  `include "tb_nes_video_ref.svh"

  nes_video_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // sender: spends one credit per index, gets one back per o_credit
  always @(posedge clk) begin : stim
    nes_video_pkg::pal_idx_t idx;
    idx = '0;
    if (rst) begin
      i_pix_valid <= 1'b0;
    end else begin
      if (o_credit) credits++;
      lfsr = lfsr_step(lfsr);   // send decision
      if (credits > 0 && frames_done != PAUSE_FRAME &&
          (lfsr[0] || credits > nes_video_pkg::FIFO_DEPTH / 2)) begin
        for (int i = 0; i < 6; i++) begin
          lfsr = lfsr_step(lfsr);
          idx  = {idx[4:0], lfsr[0]};
        end
        i_pix_valid <= 1'b1;
        i_pix_idx   <= idx;
        credits--;
        exp_q.push_back(idx);
      end else begin
        i_pix_valid <= 1'b0;
      end
      if (credits < 0 || credits > nes_video_pkg::FIFO_DEPTH) begin
        err_cnt++;
        $display("credit counter left its range at %0t: %0d", $time, credits);
      end
    end
  end

  always @(posedge clk) begin : compare
    nes_video_pkg::rgb332_t got;
    got = nes_video_pkg::rgb332_t'({o_r, o_g, o_b});
    if (rst_d1 || rst_d2) begin   // reset state and the first cycle after
      check_flag("o_de", o_de, 1'b0);
      check_flag("o_sof", o_sof, 1'b0);
      check_flag("o_hsync", o_hsync, 1'b0);
      check_flag("o_underrun", o_underrun, 1'b0);
      check_flag("o_credit", o_credit, 1'b0);
      check_flag("o_vblank", o_vblank, 1'b1);
      check_rgb("o_rgb", got, nes_video_pkg::BG_COLOR);
    end
    if (armed) begin
      if (o_credit) credit_pulses++;
      if (o_de && o_vblank) begin
        err_cnt++;
        $display("o_vblank high during an image pixel at %0t", $time);
      end
      if (!o_de) begin
        check_rgb("o_rgb", got, nes_video_pkg::BG_COLOR);
      end else if (o_underrun) begin
        check_rgb("o_rgb", got, nes_video_pkg::BG_COLOR);
        if (frames_done == PAUSE_FRAME) pause_underruns++;
      end else if (exp_q.size() == 0) begin
        err_cnt++;
        $display("pixel shown at %0t with no index sent", $time);
      end else begin
        check_rgb("o_rgb", got, ref_rgb(exp_q.pop_front()));
        shown_cnt++;
      end
      if (o_de) de_cnt++;
      if (o_sof) sof_cnt++;
      if (o_hsync && !hsync_q) hsync_runs++;
      if (o_vblank && !vblank_q) begin   // frame finished
        check_count("o_sof pulses per frame", sof_cnt, 1);
        check_count("o_hsync runs per frame", hsync_runs, nes_video_pkg::FRAME_HEIGHT);
        check_count("o_de cycles per frame", de_cnt,
                    nes_video_pkg::IMAGE_WIDTH * nes_video_pkg::IMAGE_HEIGHT);
        sof_cnt     = 0;
        hsync_runs  = 0;
        de_cnt      = 0;
        frames_done <= frames_done + 1;
      end
      hsync_q  = o_hsync;
      vblank_q = o_vblank;
    end
    armed  = armed | rst_d1;
    rst_d2 = rst_d1;
    rst_d1 = rst;
  end

  initial begin : main
    int cycles;
    rst         = 1'b1;
    i_pix_valid = 1'b0;
    i_pix_idx   = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    while (frames_done < NUM_FRAMES && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (frames_done < NUM_FRAMES) begin
      err_cnt++;
      $display("timeout: saw %0d of %0d frames", frames_done, NUM_FRAMES);
    end
    if (pause_underruns == 0) begin
      err_cnt++;
      $display("no underrun seen during the paused frame");
    end
    check_count("o_credit pulses", credit_pulses, shown_cnt);
    $display("summary: %0d errors, %0d pixels, %0d paused underruns, %0d credits",
             err_cnt, shown_cnt, pause_underruns, credit_pulses);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+.
nes_video_pkg.sv
raster_if.sv
pix_fifo.sv
raster_timer.sv
palette_lut.sv
nes_video_top.sv
nes_video_props.sv
tb_nes_video.sv

// File: Bender.yml
package:
  name: nes_video

sources:
  - nes_video_pkg.sv
  - raster_if.sv
  - pix_fifo.sv
  - raster_timer.sv
  - palette_lut.sv
  - nes_video_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - nes_video_props.sv
      - tb_nes_video.sv
